// ==== source/boot_pkg.sv ====
// ################################################
// Boot path package
// Word widths, special host addresses and the
// loader state encoding
// ################################################

package boot_pkg;

   // Word address into the host memory map
   typedef logic [11:0] addr_t;

   // One data word on the command and response channels
   typedef logic [31:0] data_t;

   // Addresses below this are backed by ordinary memory
   localparam int MEM_WORDS = 1024;

   // Instruction RAM region cleared by the configuration phase
   localparam addr_t CFG_RAM_BASE = 12'h300;

   // Core freeze register, bit 0 holds the core in freeze
   localparam addr_t FREEZE_ADDR = 12'hFF0;

   // Host finish register, any write marks the program done
   localparam addr_t FINISH_ADDR = 12'hFF8;

   // Host loader sequence
   // CFG_CLEAR     zero the instruction RAM words
   // CFG_UNFREEZE  release the core
   // CFG_DRAIN     wait for configuration responses
   // PROG          program stream owns the command channel
   typedef enum logic [1:0]
   {
      CFG_CLEAR,
      CFG_UNFREEZE,
      CFG_DRAIN,
      PROG
   } loader_state_e;

endpackage

// ==== source/host_loader.sv ====
`timescale 1ns/1ns
// ################################################
// Host loader
// Runs the configuration phase, then hands the
// command channel to the program stream
// ################################################

module host_loader
   #(parameter int instr_ram_els_p = 16
     , parameter bit skip_init_p   = 1'b0
     )
   (input  logic            clk_i
    , input  logic            reset_i

    , input  logic            prog_v_i
    , input  logic            prog_we_i
    , input  boot_pkg::addr_t prog_addr_i
    , input  boot_pkg::data_t prog_data_i
    , output logic            prog_ready_o

    , output logic            cmd_v_o
    , output logic            cmd_we_o
    , output boot_pkg::addr_t cmd_addr_o
    , output boot_pkg::data_t cmd_data_o
    , input  logic            cmd_ready_i

    , input  logic            resp_v_i
    , input  logic            resp_we_i
    , input  boot_pkg::data_t resp_data_i

    , output logic            rd_v_o
    , output boot_pkg::data_t rd_data_o
    , output logic            cfg_done_o
    );

   localparam int clr_width_lp  = (instr_ram_els_p > 1) ? $clog2(instr_ram_els_p) : 1;
   // Large enough for any queue depth set at the top
   localparam int pend_width_lp = 16;

   boot_pkg::loader_state_e  state_r;
   logic [clr_width_lp-1:0]  clr_idx_r;
   logic [pend_width_lp-1:0] pending_r;
   logic                     cmd_push;
   logic                     clr_last;

   assign cmd_push = cmd_v_o & cmd_ready_i;
   assign clr_last = (clr_idx_r == clr_width_lp'(instr_ram_els_p - 1));

   // Fixed handover, configuration and program traffic never overlap
   always_comb
   begin
      cmd_v_o      = 1'b0;
      cmd_we_o     = 1'b1;
      cmd_addr_o   = boot_pkg::CFG_RAM_BASE + boot_pkg::addr_t'(clr_idx_r);
      cmd_data_o   = '0;
      prog_ready_o = 1'b0;
      case (state_r)
         boot_pkg::CFG_CLEAR:
         begin
            cmd_v_o = 1'b1;
         end
         boot_pkg::CFG_UNFREEZE:
         begin
            cmd_v_o    = 1'b1;
            cmd_addr_o = boot_pkg::FREEZE_ADDR;
         end
         boot_pkg::PROG:
         begin
            cmd_v_o      = prog_v_i;
            cmd_we_o     = prog_we_i;
            cmd_addr_o   = prog_addr_i;
            cmd_data_o   = prog_data_i;
            prog_ready_o = cmd_ready_i;
         end
         default:
         begin
            cmd_v_o = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r   <= skip_init_p ? boot_pkg::CFG_UNFREEZE : boot_pkg::CFG_CLEAR;
         clr_idx_r <= '0;
      end
      else
      begin
         case (state_r)
            boot_pkg::CFG_CLEAR:
            begin
               if (cmd_push)
               begin
                  clr_idx_r <= clr_idx_r + 1'b1;
                  if (clr_last)
                     state_r <= boot_pkg::CFG_UNFREEZE;
               end
            end
            boot_pkg::CFG_UNFREEZE:
            begin
               if (cmd_push)
                  state_r <= boot_pkg::CFG_DRAIN;
            end
            boot_pkg::CFG_DRAIN:
            begin
               if (pending_r == '0)
                  state_r <= boot_pkg::PROG;
            end
            default:
            begin
               state_r <= boot_pkg::PROG;
            end
         endcase
      end
   end

   // Commands issued but not yet answered
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         pending_r <= '0;
      else if (cmd_push && !resp_v_i)
         pending_r <= pending_r + 1'b1;
      else if (!cmd_push && resp_v_i)
         pending_r <= pending_r - 1'b1;
   end

   // Responses are always accepted, reads go straight out
   assign rd_v_o     = resp_v_i & ~resp_we_i;
   assign rd_data_o  = resp_data_i;
   assign cfg_done_o = (state_r == boot_pkg::PROG);

   // The memory answers only commands that went through the queue
   resp_has_cmd_a: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i |-> (pending_r != '0));

endmodule

// ==== source/cmd_fifo.sv ====
`timescale 1ns/1ns
// ################################################
// Command queue
// Circular buffer, valid/ready in, valid/yumi out
// ################################################

module cmd_fifo
   #(parameter int fifo_depth_p = 4
     )
   (input  logic            clk_i
    , input  logic            reset_i

    , input  logic            push_v_i
    , input  logic            push_we_i
    , input  boot_pkg::addr_t push_addr_i
    , input  boot_pkg::data_t push_data_i
    , output logic            push_ready_o

    , output logic            head_v_o
    , output logic            head_we_o
    , output boot_pkg::addr_t head_addr_o
    , output boot_pkg::data_t head_data_o
    , input  logic            pop_yumi_i
    );

   localparam int ptr_width_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
   localparam int cnt_width_lp = $clog2(fifo_depth_p + 1);

   logic                    we_mem   [fifo_depth_p];
   boot_pkg::addr_t         addr_mem [fifo_depth_p];
   boot_pkg::data_t         data_mem [fifo_depth_p];
   logic [ptr_width_lp-1:0] rd_ptr_r;
   logic [ptr_width_lp-1:0] wr_ptr_r;
   logic [cnt_width_lp-1:0] count_r;
   logic                    push;

   // Wraps for depths that are not a power of two
   function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] ptr);
      return (ptr == ptr_width_lp'(fifo_depth_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push         = push_v_i & push_ready_o;
   assign push_ready_o = (count_r != cnt_width_lp'(fifo_depth_p));
   assign head_v_o     = (count_r != '0);
   assign head_we_o    = we_mem[rd_ptr_r];
   assign head_addr_o  = addr_mem[rd_ptr_r];
   assign head_data_o  = data_mem[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         we_mem[wr_ptr_r]   <= push_we_i;
         addr_mem[wr_ptr_r] <= push_addr_i;
         data_mem[wr_ptr_r] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= ptr_next(wr_ptr_r);
         if (pop_yumi_i)
            rd_ptr_r <= ptr_next(rd_ptr_r);
         if (push && !pop_yumi_i)
            count_r <= count_r + 1'b1;
         else if (!push && pop_yumi_i)
            count_r <= count_r - 1'b1;
      end
   end

   // A command refused while full stays offered unchanged
   full_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (push_v_i && !push_ready_o)
      |=> (push_v_i && $stable({push_we_i, push_addr_i, push_data_i})));

   no_pop_empty_a: assert property (@(posedge clk_i) disable iff (reset_i)
      pop_yumi_i |-> head_v_o);

endmodule

// ==== source/mem_model.sv ====
`timescale 1ns/1ns
// ################################################
// Memory model with host registers
// One command at a time, pseudo-random latency,
// freeze and program-finish registers
// ################################################

module mem_model
   #(parameter int max_latency_p = 7
     )
   (input  logic            clk_i
    , input  logic            reset_i

    , input  logic            cmd_v_i
    , input  logic            cmd_we_i
    , input  boot_pkg::addr_t cmd_addr_i
    , input  boot_pkg::data_t cmd_data_i
    , output logic            cmd_yumi_o

    , output logic            resp_v_o
    , output logic            resp_we_o
    , output boot_pkg::data_t resp_data_o

    , output logic            freeze_o
    , output logic            program_finish_o
    );

   localparam int lat_width_lp = (max_latency_p > 0) ? $clog2(max_latency_p + 1) : 1;
   localparam int idx_width_lp = $clog2(boot_pkg::MEM_WORDS);

   boot_pkg::data_t         mem_r [boot_pkg::MEM_WORDS];
   logic [15:0]             lfsr_r;
   logic                    lfsr_fb;
   logic [lat_width_lp-1:0] lat_cnt_r;
   logic [lat_width_lp-1:0] lat_pick;
   logic                    busy_r;
   logic                    take;
   logic                    in_mem;
   logic [idx_width_lp-1:0] mem_idx;
   boot_pkg::data_t         rd_word;
   logic                    freeze_r;
   logic                    finish_r;
   logic                    resp_we_r;
   boot_pkg::data_t         resp_data_r;

   // x^16 + x^14 + x^13 + x^11 + 1
   assign lfsr_fb  = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
   assign lat_pick = lat_width_lp'(lfsr_r % (max_latency_p + 1));

   assign take    = cmd_v_i & ~busy_r;
   assign in_mem  = (cmd_addr_i < boot_pkg::MEM_WORDS);
   assign mem_idx = cmd_addr_i[idx_width_lp-1:0];

   always_comb
   begin
      if (in_mem)
         rd_word = mem_r[mem_idx];
      else if (cmd_addr_i == boot_pkg::FREEZE_ADDR)
         rd_word = boot_pkg::data_t'(freeze_r);
      else
         rd_word = '0;
   end

   // Access happens at take, the response waits out the latency
   always_ff @(posedge clk_i)
   begin
      if (take)
      begin
         resp_we_r   <= cmd_we_i;
         resp_data_r <= cmd_we_i ? '0 : rd_word;
         if (cmd_we_i && in_mem)
            mem_r[mem_idx] <= cmd_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         lfsr_r    <= 16'hACE1;
         busy_r    <= 1'b0;
         lat_cnt_r <= '0;
         freeze_r  <= 1'b1;
         finish_r  <= 1'b0;
      end
      else
      begin
         lfsr_r <= {lfsr_r[14:0], lfsr_fb};
         if (take)
         begin
            busy_r    <= 1'b1;
            lat_cnt_r <= lat_pick;
         end
         else if (resp_v_o)
            busy_r <= 1'b0;
         else if (busy_r)
            lat_cnt_r <= lat_cnt_r - 1'b1;

         if (take && cmd_we_i)
         begin
            // Finish is sticky until reset
            if (cmd_addr_i == boot_pkg::FINISH_ADDR)
               finish_r <= 1'b1;
            if (cmd_addr_i == boot_pkg::FREEZE_ADDR)
               freeze_r <= cmd_data_i[0];
         end
      end
   end

   assign cmd_yumi_o       = take;
   assign resp_v_o         = busy_r & (lat_cnt_r == '0);
   assign resp_we_o        = resp_we_r;
   assign resp_data_o      = resp_data_r;
   assign freeze_o         = freeze_r;
   assign program_finish_o = finish_r;

   lat_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
      busy_r |-> (lat_cnt_r <= max_latency_p));

endmodule

// ==== source/boot_top.sv ====
`timescale 1ns/1ns
// ################################################
// Boot path top level
// Host loader feeding the memory model through
// the command queue
// ################################################

module boot_top
   #(parameter int fifo_depth_p    = 4
     , parameter int max_latency_p   = 7
     , parameter int instr_ram_els_p = 16
     , parameter bit skip_init_p     = 1'b0
     )
   (input  logic            clk_i
    , input  logic            reset_i

    , input  logic            prog_v_i
    , input  logic            prog_we_i
    , input  boot_pkg::addr_t prog_addr_i
    , input  boot_pkg::data_t prog_data_i
    , output logic            prog_ready_o

    , output logic            rd_v_o
    , output boot_pkg::data_t rd_data_o
    , output logic            cfg_done_o
    , output logic            freeze_o
    , output logic            program_finish_o
    );

   logic            cmd_v;
   logic            cmd_we;
   boot_pkg::addr_t cmd_addr;
   boot_pkg::data_t cmd_data;
   logic            cmd_ready;

   logic            head_v;
   logic            head_we;
   boot_pkg::addr_t head_addr;
   boot_pkg::data_t head_data;
   logic            head_yumi;

   logic            resp_v;
   logic            resp_we;
   boot_pkg::data_t resp_data;

   host_loader
      #(.instr_ram_els_p(instr_ram_els_p)
        ,.skip_init_p(skip_init_p)
        )
      u_host_loader
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.prog_v_i(prog_v_i)
       ,.prog_we_i(prog_we_i)
       ,.prog_addr_i(prog_addr_i)
       ,.prog_data_i(prog_data_i)
       ,.prog_ready_o(prog_ready_o)
       ,.cmd_v_o(cmd_v)
       ,.cmd_we_o(cmd_we)
       ,.cmd_addr_o(cmd_addr)
       ,.cmd_data_o(cmd_data)
       ,.cmd_ready_i(cmd_ready)
       ,.resp_v_i(resp_v)
       ,.resp_we_i(resp_we)
       ,.resp_data_i(resp_data)
       ,.rd_v_o(rd_v_o)
       ,.rd_data_o(rd_data_o)
       ,.cfg_done_o(cfg_done_o)
       );

   cmd_fifo
      #(.fifo_depth_p(fifo_depth_p))
      u_cmd_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.push_v_i(cmd_v)
       ,.push_we_i(cmd_we)
       ,.push_addr_i(cmd_addr)
       ,.push_data_i(cmd_data)
       ,.push_ready_o(cmd_ready)
       ,.head_v_o(head_v)
       ,.head_we_o(head_we)
       ,.head_addr_o(head_addr)
       ,.head_data_o(head_data)
       ,.pop_yumi_i(head_yumi)
       );

   mem_model
      #(.max_latency_p(max_latency_p))
      u_mem_model
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.cmd_v_i(head_v)
       ,.cmd_we_i(head_we)
       ,.cmd_addr_i(head_addr)
       ,.cmd_data_i(head_data)
       ,.cmd_yumi_o(head_yumi)
       ,.resp_v_o(resp_v)
       ,.resp_we_o(resp_we)
       ,.resp_data_o(resp_data)
       ,.freeze_o(freeze_o)
       ,.program_finish_o(program_finish_o)
       );

endmodule

// ==== tb/mem_ref_model.sv ====
`timescale 1ns/1ns
// ################################################
// Reference memory for the boot path testbench
// Tracks accepted program commands and queues the
// expected data of every read
// ################################################

module mem_ref_model
   (input  logic            clk_i
    , input  logic            reset_i
    , input  logic            cfg_done_i

    , input  logic            acc_v_i
    , input  logic            acc_we_i
    , input  boot_pkg::addr_t acc_addr_i
    , input  boot_pkg::data_t acc_data_i

    , input  logic            pop_i
    , output logic            exp_v_o
    , output boot_pkg::data_t exp_data_o
    );

   boot_pkg::data_t mem_r [boot_pkg::MEM_WORDS];
   boot_pkg::data_t exp_q [1024];
   logic [9:0]      wr_idx_r;
   logic [9:0]      rd_idx_r;
   logic            freeze_r;
   logic            unfrozen_r;
   logic            freeze_now;
   logic            in_mem;
   boot_pkg::data_t rd_word;

   // Core stays frozen until the configuration phase ends
   assign freeze_now = unfrozen_r ? freeze_r : ~cfg_done_i;
   assign in_mem     = (acc_addr_i < boot_pkg::MEM_WORDS);

   always_comb
   begin
      if (in_mem)
         rd_word = mem_r[acc_addr_i[9:0]];
      else if (acc_addr_i == boot_pkg::FREEZE_ADDR)
         rd_word = boot_pkg::data_t'(freeze_now);
      else
         rd_word = '0;
   end

   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         // Cleared instruction RAM reads back as zero
         for (int i = 0; i < boot_pkg::MEM_WORDS; i++)
            mem_r[i] <= '0;
         wr_idx_r   <= '0;
         rd_idx_r   <= '0;
         freeze_r   <= 1'b1;
         unfrozen_r <= 1'b0;
      end
      else
      begin
         unfrozen_r <= unfrozen_r | cfg_done_i;
         freeze_r   <= freeze_now;
         if (acc_v_i && acc_we_i && in_mem)
            mem_r[acc_addr_i[9:0]] <= acc_data_i;
         if (acc_v_i && acc_we_i && (acc_addr_i == boot_pkg::FREEZE_ADDR))
            freeze_r <= acc_data_i[0];
         if (acc_v_i && !acc_we_i)
         begin
            exp_q[wr_idx_r] <= rd_word;
            wr_idx_r        <= wr_idx_r + 1'b1;
         end
         if (pop_i)
            rd_idx_r <= rd_idx_r + 1'b1;
      end
   end

   assign exp_v_o    = (wr_idx_r != rd_idx_r);
   assign exp_data_o = exp_q[rd_idx_r];

endmodule

// ==== tb/tb_boot_top.sv ====
`timescale 1ns/1ns
// ################################################
// Boot path testbench
// Random program traffic after the configuration
// phase, read data checked against a reference
// ################################################

module tb_boot_top;

   localparam int fifo_depth_lp    = 4;
   localparam int max_latency_lp   = 7;
   localparam int instr_ram_els_lp = 16;
   localparam bit skip_init_lp     = 1'b0;
   localparam int num_cmds_lp      = 600;
   localparam int burst_cmds_lp    = 100;
   localparam int timeout_lp       =
      (num_cmds_lp + instr_ram_els_lp + 2) * (max_latency_lp + 3) + 200;

   logic            clk_i = 1'b0;
   logic            reset_i;
   logic            prog_v_i;
   logic            prog_we_i;
   boot_pkg::addr_t prog_addr_i;
   boot_pkg::data_t prog_data_i;
   logic            prog_ready_o;
   logic            rd_v_o;
   boot_pkg::data_t rd_data_o;
   logic            cfg_done_o;
   logic            freeze_o;
   logic            program_finish_o;

   logic            exp_v;
   boot_pkg::data_t exp_data;
   int              cycle_cnt;
   int              rd_cnt;
   int              rd_acc_cnt;
   logic            stall_seen;
   logic            finish_sent;
   boot_pkg::addr_t known_q [$];

   always #4 clk_i = ~clk_i;

   boot_top
      #(.fifo_depth_p(fifo_depth_lp)
        ,.max_latency_p(max_latency_lp)
        ,.instr_ram_els_p(instr_ram_els_lp)
        ,.skip_init_p(skip_init_lp)
        )
      u_dut
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.prog_v_i(prog_v_i)
       ,.prog_we_i(prog_we_i)
       ,.prog_addr_i(prog_addr_i)
       ,.prog_data_i(prog_data_i)
       ,.prog_ready_o(prog_ready_o)
       ,.rd_v_o(rd_v_o)
       ,.rd_data_o(rd_data_o)
       ,.cfg_done_o(cfg_done_o)
       ,.freeze_o(freeze_o)
       ,.program_finish_o(program_finish_o)
       );

   mem_ref_model u_ref
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.cfg_done_i(cfg_done_o)
       ,.acc_v_i(prog_v_i & prog_ready_o)
       ,.acc_we_i(prog_we_i)
       ,.acc_addr_i(prog_addr_i)
       ,.acc_data_i(prog_data_i)
       ,.pop_i(rd_v_o)
       ,.exp_v_o(exp_v)
       ,.exp_data_o(exp_data)
       );

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
         $display("** FAIL **");
         $fatal(1, "Check failed");
      end
   endtask

   // Holds the command until the loader takes it
   task automatic send_cmd(input logic we, input boot_pkg::addr_t addr,
                           input boot_pkg::data_t data);
      prog_v_i    <= 1'b1;
      prog_we_i   <= we;
      prog_addr_i <= addr;
      prog_data_i <= data;
      @(posedge clk_i);
      while (!prog_ready_o)
         @(posedge clk_i);
      prog_v_i <= 1'b0;
   endtask

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == timeout_lp)
      begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_lp);
         $display("** FAIL **");
         $fatal(1, "Timeout");
      end
   end

   always @(posedge clk_i)
   begin
      if (!reset_i)
      begin
         check_value(32'(prog_ready_o & ~cfg_done_o), 0, "prog_ready_o before cfg_done_o");
         check_value(32'(program_finish_o & ~finish_sent), 0, "early program_finish_o");
         if (rd_v_o)
         begin
            check_value(32'(exp_v), 1, "read response with no read outstanding");
            check_value(rd_data_o, exp_data, "read data");
            rd_cnt <= rd_cnt + 1;
         end
         if (prog_v_i && prog_ready_o && !prog_we_i)
            rd_acc_cnt <= rd_acc_cnt + 1;
         if (cfg_done_o && prog_v_i && !prog_ready_o)
            stall_seen <= 1'b1;
      end
   end

   initial
   begin
      logic            we;
      boot_pkg::addr_t addr;
      int              n_cfg_reads;

      void'($urandom(32'h85c4_3c9c));
      reset_i     = 1'b1;
      prog_v_i    = 1'b0;
      prog_we_i   = 1'b0;
      prog_addr_i = '0;
      prog_data_i = '0;
      cycle_cnt   = 0;
      rd_cnt      = 0;
      rd_acc_cnt  = 0;
      stall_seen  = 1'b0;
      finish_sent = 1'b0;
      n_cfg_reads = skip_init_lp ? 0 : instr_ram_els_lp;
      for (int i = 0; i < n_cfg_reads; i++)
         known_q.push_back(boot_pkg::addr_t'(boot_pkg::CFG_RAM_BASE + i));
      known_q.push_back(boot_pkg::FREEZE_ADDR);

      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i);
      check_value(32'(freeze_o), 1, "freeze_o after reset");
      check_value(32'(cfg_done_o), 0, "cfg_done_o after reset");
      check_value(32'(prog_ready_o), 0, "prog_ready_o after reset");
      check_value(32'(rd_v_o), 0, "rd_v_o after reset");
      check_value(32'(program_finish_o), 0, "program_finish_o after reset");

      while (!cfg_done_o)
         @(posedge clk_i);
      check_value(32'(freeze_o), 0, "freeze_o at cfg_done_o");

      // Cleared region and freeze register first, then random traffic
      for (int i = 0; i < num_cmds_lp; i++)
      begin
         if (i < n_cfg_reads)
         begin
            we   = 1'b0;
            addr = boot_pkg::addr_t'(boot_pkg::CFG_RAM_BASE + i);
         end
         else if (i == n_cfg_reads)
         begin
            we   = 1'b0;
            addr = boot_pkg::FREEZE_ADDR;
         end
         else
         begin
            we = (($urandom % 5) >= 2);
            if (we)
               addr = boot_pkg::addr_t'($urandom % boot_pkg::MEM_WORDS);
            else
               addr = known_q[$urandom % known_q.size()];
         end
         send_cmd(we, addr, $urandom);
         if (we)
            known_q.push_back(addr);
         if ((i >= burst_cmds_lp) && (($urandom % 3) == 0))
            repeat ($urandom % 4) @(posedge clk_i);
      end

      send_cmd(1'b1, boot_pkg::FINISH_ADDR, $urandom);
      finish_sent = 1'b1;
      while (!program_finish_o)
         @(posedge clk_i);
      repeat (4)
      begin
         @(posedge clk_i);
         check_value(32'(program_finish_o), 1, "program_finish_o did not stay high");
      end
      check_value(rd_cnt, rd_acc_cnt, "read response count");
      check_value(32'(exp_v), 0, "reads left without a response");
      check_value(32'(stall_seen), 1, "prog_ready_o never dropped under the burst");
      $display("** PASS **");
      $finish;
   end

endmodule

// ==== flist.f ====
source/boot_pkg.sv
source/host_loader.sv
source/cmd_fifo.sv
source/mem_model.sv
source/boot_top.sv
tb/mem_ref_model.sv
tb/tb_boot_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the boot path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_boot_top -f flist.f -o sim_boot
if [ $? -ne 0 ]; then
   echo "Compilation failed"
   exit 1
fi

./obj_dir/sim_boot > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
   echo "Simulation failed"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"
exit 0
